/* hdl/sched_cfg_pkg.sv */
`default_nettype none

// build-wide sizing for the request scheduler
package sched_cfg_pkg;

    // bits in one request address
    localparam int ADDR_W = 8;

    // default slots per address queue
    // must be a power of two and at least 2 so the pointers wrap for free
    // one slot always stays empty, which leaves DEF_DEPTH-1 usable entries
    localparam int DEF_DEPTH = 4;

endpackage : sched_cfg_pkg

`default_nettype wire

/* hdl/sched_types_pkg.sv */
`default_nettype none

// data types shared by the queues, the hazard check and the control
package sched_types_pkg;

    import sched_cfg_pkg::*;

    // one request address, as seen on in_addr and out_addr
    typedef logic [ADDR_W-1:0] addr_t;

    // issue decision of the control FSM
    // the registered copy names the source of the last issue
    typedef enum logic [1:0] {
        SRC_NONE  = 2'd0,   // nothing granted or nothing queued
        SRC_READ  = 2'd1,   // head of the read queue went out
        SRC_WRITE = 2'd2    // head of the write queue went out
    } issue_src_e;

endpackage : sched_types_pkg

`default_nettype wire

/* hdl/queue_if.sv */
`default_nettype none

// one address queue as seen by the store, the control and the hazard scan
interface queue_if
    import sched_cfg_pkg::*, sched_types_pkg::*;
#(
    parameter int DEPTH = DEF_DEPTH
) ();

    logic                    push;        // write push_addr at the tail
    addr_t                   push_addr;
    logic                    pop;         // drop the head entry
    addr_t                   head_addr;   // oldest entry, valid when !empty
    logic                    full;        // DEPTH-1 entries held
    logic                    empty;
    addr_t [DEPTH-1:0]       entries;     // raw storage, slot indexed
    logic  [DEPTH-1:0]       live_mask;   // 1 = slot holds a queued entry

    // queue storage side
    modport store (
        input  push, push_addr, pop,
        output head_addr, full, empty, entries, live_mask
    );

    // ingress steering and issue side
    modport ctrl (
        output push, push_addr, pop,
        input  head_addr, full, empty
    );

    // read only view for the hazard compare
    modport scan (
        input  head_addr, empty, entries, live_mask
    );

endinterface : queue_if

`default_nettype wire

/* hdl/addr_queue.sv */
`default_nettype none

// circular FIFO of request addresses
// one slot is sacrificed so that equal pointers always mean empty
module addr_queue
    import sched_cfg_pkg::*, sched_types_pkg::*;
#(
    parameter int DEPTH = DEF_DEPTH
) (
    input  logic  clkin,
    input  logic  arst_n,
    queue_if.store q
);

    localparam int PTR_W = $clog2(DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;

    addr_t [DEPTH-1:0] mem;      // address storage
    ptr_t              head;     // next entry to leave
    ptr_t              tail;     // next free slot
    ptr_t              count;    // entries held, modulo DEPTH

    // storage write, no reset needed on the payload
    always_ff @(posedge clkin) begin
        if (q.push) begin
            mem[tail] <= q.push_addr;
        end
    end

    // pointer update
    always_ff @(posedge clkin or negedge arst_n) begin
        if (!arst_n) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (q.push) begin
                tail <= tail + 1'b1;   // wraps at DEPTH, power of two
            end
            if (q.pop) begin
                head <= head + 1'b1;
            end
        end
    end

    // status straight from the pointers
    assign q.empty     = (head == tail);
    assign q.full      = (ptr_t'(tail + 1'b1) == head);   // tail one behind head
    assign q.head_addr = mem[head];
    assign q.entries   = mem;

    assign count = tail - head;   // modular difference handles wrap

    // a slot is live when its distance from head is below the count
    // this covers both the plain and the wrapped pointer order
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            q.live_mask[i] = (ptr_t'(ptr_t'(i) - head) < count);
        end
    end

    // the control must look at full before it steers a request here
    push_not_full: assert property (
        @(posedge clkin) disable iff (!arst_n)
        q.push |-> !q.full
    ) else $error("push into a full address queue");

    // the issue logic only picks a queue that holds something
    pop_not_empty: assert property (
        @(posedge clkin) disable iff (!arst_n)
        q.pop |-> !q.empty
    ) else $error("pop from an empty address queue");

endmodule : addr_queue

`default_nettype wire

/* hdl/raw_hazard_detect.sv */
`default_nettype none

// read-after-write check
// the read head may not pass a queued write to the same address
module raw_hazard_detect
    import sched_cfg_pkg::*, sched_types_pkg::*;
#(
    parameter int DEPTH = DEF_DEPTH
) (
    queue_if.scan rdq,
    queue_if.scan wrq,
    output logic  hazard
);

    addr_t rd_head;       // address the read queue wants to issue next
    logic  rd_live;       // read queue holds at least one entry
    logic  hit;           // some live write slot holds rd_head

    assign rd_head = rdq.head_addr;
    assign rd_live = |rdq.live_mask;   // occupancy taken from the slot mask

    // compare against every slot, stale slots masked out by live_mask
    always_comb begin
        hit = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            if (wrq.live_mask[i] && (wrq.entries[i] == rd_head)) begin
                hit = 1'b1;
            end
        end
    end

    // an empty read queue leaves rd_head stale, so no hazard then
    // an empty write queue has no live bits anyway, quick out
    assign hazard = hit && rd_live && !wrq.empty;

    // no clock on this block, so a deferred check on the settled value
    // slot mask and empty flag of the read queue have to agree
    always_comb begin
        hazard_needs_read: assert final (!(hazard && rdq.empty))
            else $error("hazard raised while the read queue is empty");
    end

endmodule : raw_hazard_detect

`default_nettype wire

/* hdl/sched_control.sv */
`default_nettype none

// ingress steering and issue FSM
// grant is registered once, the chosen head is registered into the outputs
module sched_control
    import sched_types_pkg::*;
(
    input  logic  clkin,
    input  logic  arst_n,
    // client side
    input  logic  in_valid,
    input  logic  in_is_read,
    input  addr_t in_addr,
    output logic  in_ready,
    // bus side
    input  logic  bus_gnt_raw,
    input  logic  hazard,        // read head matches a queued write
    queue_if.ctrl rdq,
    queue_if.ctrl wrq,
    output logic  out_valid,
    output logic  out_is_read,
    output addr_t out_addr
);

    logic       accept;          // handshake this cycle
    logic       grant_q;         // bus grant, one edge late
    issue_src_e src_d;           // decision for the coming edge
    issue_src_e last_src;        // source of the last issue

    // ingress
    assign in_ready = in_is_read ? !rdq.full : !wrq.full;   // only the target queue matters
    assign accept   = in_valid && in_ready;

    assign rdq.push      = accept && in_is_read;
    assign wrq.push      = accept && !in_is_read;
    assign rdq.push_addr = in_addr;
    assign wrq.push_addr = in_addr;

    // issue decision on queue state from before the edge
    always_comb begin
        src_d = SRC_NONE;
        if (grant_q) begin
            if (!rdq.empty && !hazard) begin
                src_d = SRC_READ;    // reads go ahead of writes
            end else if (!wrq.empty) begin
                src_d = SRC_WRITE;   // also drains the write that blocks a read
            end
        end
    end

    assign rdq.pop = (src_d == SRC_READ);
    assign wrq.pop = (src_d == SRC_WRITE);

    // control state
    always_ff @(posedge clkin or negedge arst_n) begin
        if (!arst_n) begin
            grant_q   <= 1'b0;
            last_src  <= SRC_NONE;
            out_valid <= 1'b0;
        end else begin
            grant_q   <= bus_gnt_raw;
            last_src  <= src_d;
            out_valid <= (src_d != SRC_NONE);   // one cycle per issue
        end
    end

    // issued address, payload only
    always_ff @(posedge clkin) begin
        if (src_d == SRC_READ) begin
            out_addr <= rdq.head_addr;
        end else if (src_d == SRC_WRITE) begin
            out_addr <= wrq.head_addr;
        end
    end

    assign out_is_read = (last_src == SRC_READ);

    // a read leaving the queue must not have had a pending write match
    read_after_clear: assert property (
        @(posedge clkin) disable iff (!arst_n)
        (out_valid && out_is_read) |-> !$past(hazard)
    ) else $error("read issued while a matching write was queued");

    // output strobe and recorded source must agree
    valid_has_source: assert property (
        @(posedge clkin) disable iff (!arst_n)
        out_valid |-> (last_src != SRC_NONE)
    ) else $error("out_valid high with no issue source recorded");

endmodule : sched_control

`default_nettype wire

/* hdl/req_sched_top.sv */
`default_nettype none

// memory request scheduler
// two address queues, a read-after-write check and the issue control
module req_sched_top
    import sched_cfg_pkg::*, sched_types_pkg::*;
#(
    parameter int DEPTH = DEF_DEPTH    // slots per queue, power of two
) (
    input  logic  clkin,
    input  logic  arst_n,
    // request ingress
    input  logic  in_valid,
    input  logic  in_is_read,          // 1 = read, 0 = write
    input  addr_t in_addr,
    output logic  in_ready,            // selected queue has room
    // bus side
    input  logic  bus_gnt_raw,         // slot offered by the bus
    output logic  out_valid,           // one request issued
    output logic  out_is_read,
    output addr_t out_addr
);

    logic hazard;   // read head blocked by a queued write

    // queue bundles
    queue_if #(
        .DEPTH (DEPTH)
    ) rdq_if ();

    queue_if #(
        .DEPTH (DEPTH)
    ) wrq_if ();

    // read address queue
    addr_queue #(
        .DEPTH (DEPTH)
    ) u_rdq (
        .clkin  (clkin),
        .arst_n (arst_n),
        .q      (rdq_if)
    );

    // write address queue
    addr_queue #(
        .DEPTH (DEPTH)
    ) u_wrq (
        .clkin  (clkin),
        .arst_n (arst_n),
        .q      (wrq_if)
    );

    // combinational match of read head against live writes
    raw_hazard_detect #(
        .DEPTH (DEPTH)
    ) u_hazard (
        .rdq    (rdq_if),
        .wrq    (wrq_if),
        .hazard (hazard)
    );

    // steering, grant register and issue
    sched_control u_ctrl (
        .clkin       (clkin),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .in_is_read  (in_is_read),
        .in_addr     (in_addr),
        .in_ready    (in_ready),
        .bus_gnt_raw (bus_gnt_raw),
        .hazard      (hazard),
        .rdq         (rdq_if),
        .wrq         (wrq_if),
        .out_valid   (out_valid),
        .out_is_read (out_is_read),
        .out_addr    (out_addr)
    );

endmodule : req_sched_top

`default_nettype wire

/* verif/req_sched_tb.sv */
`default_nettype none

module req_sched_tb
    import sched_cfg_pkg::*, sched_types_pkg::*;
();

    localparam int DEPTH  = 4;
    localparam int N_RAND = 60;      // random rows after the directed part

    // one stimulus row, hold counts cycles the row stays applied
    typedef struct packed {
        logic       valid;
        logic       is_read;
        addr_t      addr;
        logic       gnt;
        logic [7:0] hold;
        logic       chk_rdy;         // compare in_ready on the first cycle
        logic       exp_rdy;
    } row_t;

    logic  clkin = 1'b0;
    logic  arst_n;
    logic  in_valid;
    logic  in_is_read;
    addr_t in_addr;
    logic  in_ready;
    logic  bus_gnt_raw;
    logic  out_valid;
    logic  out_is_read;
    addr_t out_addr;

    row_t   rows[$];
    addr_t  rq[$];                   // reference read queue
    addr_t  wq[$];                   // reference write queue
    logic   mgrant;                  // reference copy of the registered grant
    logic   exp_valid;
    logic   exp_rd;
    addr_t  exp_addr;
    int     value_errs = 0;
    int     proto_errs = 0;
    int     n_accepted = 0;
    int     n_issued   = 0;
    int     n_fixed;
    int     total_hold;
    longint wd_limit;
    logic   table_ready = 1'b0;
    int     seed = 32'h202;

    always #50 clkin = ~clkin;       // 100 unit period

    req_sched_top #(
        .DEPTH (DEPTH)
    ) u_req_sched_top (
        .clkin       (clkin),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .in_is_read  (in_is_read),
        .in_addr     (in_addr),
        .in_ready    (in_ready),
        .bus_gnt_raw (bus_gnt_raw),
        .out_valid   (out_valid),
        .out_is_read (out_is_read),
        .out_addr    (out_addr)
    );

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            value_errs++;
            $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            value_errs++;
            $display("ERROR %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic add_row(input logic v, input logic rd, input addr_t a, input logic g,
                           input int hold, input logic chk, input logic exp);
        row_t r;
        r.valid   = v;
        r.is_read = rd;
        r.addr    = a;
        r.gnt     = g;
        r.hold    = hold[7:0];
        r.chk_rdy = chk;
        r.exp_rdy = exp;
        rows.push_back(r);
    endtask

    // the selected queue keeps one slot free, so DEPTH-1 entries means full
    function automatic logic model_ready(input logic rd);
        return rd ? (rq.size() < DEPTH - 1) : (wq.size() < DEPTH - 1);
    endfunction

    // read head matches some write still waiting
    function automatic logic read_blocked();
        logic hit;
        hit = 1'b0;
        foreach (wq[i]) begin
            if (wq[i] == rq[0]) hit = 1'b1;
        end
        return hit;
    endfunction

    // expected issue at the coming edge, from contents before the edge
    task automatic predict_edge(input logic acc, input logic rd, input addr_t a,
                                input logic g);
        exp_valid = 1'b0;
        if (mgrant) begin
            if (rq.size() != 0 && !read_blocked()) begin
                exp_valid = 1'b1;
                exp_rd    = 1'b1;
                exp_addr  = rq.pop_front();
            end else if (wq.size() != 0) begin
                exp_valid = 1'b1;    // oldest write, also clears a hazard
                exp_rd    = 1'b0;
                exp_addr  = wq.pop_front();
            end
        end
        if (acc) begin
            if (rd) rq.push_back(a);
            else wq.push_back(a);
            n_accepted++;
        end
        mgrant = g;                  // grant seen one edge late
    endtask

    task automatic compare_outputs();
        if (out_valid === 1'b1) n_issued++;
        if (out_valid !== exp_valid) begin
            proto_errs++;
            if (exp_valid)
                $display("at %0t the scheduler did not issue %s %h when it should have",
                         $time, exp_rd ? "read" : "write", exp_addr);
            else
                $display("at %0t out_valid was %b although nothing was due to issue",
                         $time, out_valid);
        end else if (exp_valid) begin
            check_flag(out_is_read, exp_rd, "out_is_read");
            check_addr(out_addr, exp_addr, "out_addr");
        end
    endtask

    // one clock, entered and left on a falling edge
    task automatic run_cycle(input logic v, input logic rd, input addr_t a, input logic g,
                             input logic chk, input logic exp, output logic acc);
        in_valid    = v;
        in_is_read  = rd;
        in_addr     = a;
        bus_gnt_raw = g;
        #1;                          // let in_ready settle on the new kind
        if (chk) check_flag(in_ready, exp, "in_ready from table");
        check_flag(in_ready, model_ready(rd), "in_ready");
        acc = v && in_ready;
        predict_edge(acc, rd, a, g);
        @(negedge clkin);
        compare_outputs();
    endtask

    // a stalled request stays put past its hold, grant forced on so it drains
    task automatic apply_row(input row_t r);
        int   n;
        logic pending;
        logic acc;
        logic g;
        n       = 0;
        pending = r.valid;
        while (n < int'(r.hold) || pending) begin
            g = (n < int'(r.hold)) ? r.gnt : 1'b1;
            run_cycle(pending, r.is_read, r.addr, g, r.chk_rdy && n == 0, r.exp_rdy, acc);
            if (acc) pending = 1'b0;
            n++;
        end
    endtask

    task automatic build_table();
        // idle with grant low, then reads ahead of the older writes
        add_row(1, 0, 8'h10, 0, 1, 1, 1);
        add_row(1, 0, 8'h20, 0, 1, 1, 1);
        add_row(1, 1, 8'h30, 0, 1, 1, 1);
        add_row(1, 1, 8'h40, 0, 1, 1, 1);
        add_row(0, 0, 8'h00, 0, 3, 0, 0);   // grant withheld, nothing leaves
        add_row(0, 0, 8'h00, 1, 6, 0, 0);
        add_row(0, 0, 8'h00, 0, 2, 0, 0);
        // read 60 has to wait behind write 60
        add_row(1, 0, 8'h50, 0, 1, 1, 1);
        add_row(1, 0, 8'h60, 0, 1, 1, 1);
        add_row(1, 1, 8'h60, 0, 1, 1, 1);
        add_row(1, 1, 8'h70, 0, 1, 1, 1);
        add_row(0, 0, 8'h00, 1, 6, 0, 0);
        add_row(0, 0, 8'h00, 0, 2, 0, 0);
        // fill the read queue, writes still get in
        add_row(1, 1, 8'h80, 0, 1, 1, 1);
        add_row(1, 1, 8'h81, 0, 1, 1, 1);
        add_row(1, 1, 8'h82, 0, 1, 1, 1);
        add_row(1, 0, 8'h90, 0, 1, 1, 1);
        add_row(1, 1, 8'h83, 0, 3, 1, 0);   // stalls until grant drains a read
        add_row(0, 0, 8'h00, 1, 8, 0, 0);
        add_row(0, 0, 8'h00, 0, 2, 0, 0);
        n_fixed = rows.size();
        for (int i = 0; i < N_RAND; i++) begin
            // few addresses, so read-after-write matches are common
            add_row(($urandom % 5) != 0, $urandom % 2, 8'hA0 | addr_t'($urandom % 4),
                    ($urandom % 4) != 0, 1 + $urandom % 3, 0, 0);
        end
        add_row(0, 0, 8'h00, 1, 12, 0, 0);  // drain whatever is left
        add_row(0, 0, 8'h00, 0, 2, 0, 0);
        total_hold = 0;
        foreach (rows[i]) total_hold += int'(rows[i].hold);
        wd_limit    = longint'(n_fixed + N_RAND + 20) * total_hold * 100;
        table_ready = 1'b1;
    endtask

    initial begin : watchdog
        wait (table_ready === 1'b1);
        #(wd_limit);
        $display("timeout: the scheduler run did not finish within %0d time units", wd_limit);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        arst_n      = 1'b0;
        in_valid    = 1'b0;
        in_is_read  = 1'b0;
        in_addr     = '0;
        bus_gnt_raw = 1'b0;
        mgrant      = 1'b0;
        exp_valid   = 1'b0;
        exp_rd      = 1'b0;
        exp_addr    = '0;
        void'($urandom(seed));
        build_table();
        repeat (10) @(negedge clkin);
        arst_n = 1'b1;
        check_flag(out_valid, 1'b0, "out_valid after reset");
        check_flag(in_ready, 1'b1, "in_ready after reset");
        foreach (rows[i]) apply_row(rows[i]);
        if (n_issued != n_accepted) begin
            proto_errs++;
            $display("%0d requests were accepted but %0d were issued", n_accepted, n_issued);
        end
        if (rq.size() + wq.size() != 0) begin
            proto_errs++;
            $display("%0d requests were still queued when the run ended",
                     rq.size() + wq.size());
        end
        $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
        if (value_errs + proto_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule : req_sched_tb

`default_nettype wire

/* all.f */
hdl/sched_cfg_pkg.sv
hdl/sched_types_pkg.sv
hdl/queue_if.sv
hdl/addr_queue.sv
hdl/raw_hazard_detect.sv
hdl/sched_control.sv
hdl/req_sched_top.sv
verif/req_sched_tb.sv
